// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - include_dirs:
      - design
    files:
      - design/issue_pkg.sv
      - design/issue_if.sv
      - design/pair_decoder.sv
      - design/issue_queue.sv
      - design/issue_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/issue_tb.sv

// ==== design/issue_if.sv ====
`timescale 1ns/1ps

// Decoded pair from the decoder register into the issue queue.
interface issue_if import issue_pkg::*; ();

  decoded_t pair0; // Older of the two words.
  decoded_t pair1;
  logic     flush; // High for one cycle after a clear.

  modport producer (
    output pair0,
    output pair1,
    output flush
  );

  modport consumer (
    input pair0,
    input pair1,
    input flush
  );

endinterface

// ==== design/issue_macros.svh ====
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// ##############################
// Issue stage sizing
// ##############################

// Number of issue queue entries. Keep it a power of two and at least four.
`define ISSUE_DEPTH 8

// Instruction word and program counter width.
`define XLEN 32

// Integer register address width.
`define REG_ADDR_W 5

`endif

// ==== design/issue_pkg.sv ====
`include "issue_macros.svh"

package issue_pkg;

  // ##############################
  // Encodings
  // ##############################

  // RV32 major opcodes as found in bits 6:0 of the instruction word.
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_fence  = 7'b0001111,
    op_system = 7'b1110011
  } opcode_t;

  // Functional unit an instruction occupies in the execution lanes.
  typedef enum logic [2:0] {
    unit_none = 3'd0,
    unit_alu  = 3'd1,
    unit_lsu  = 3'd2,
    unit_bcu  = 3'd3,
    unit_mul  = 3'd4,
    unit_div  = 3'd5,
    unit_csr  = 3'd6
  } unit_t;

  localparam logic [`XLEN-1:0] instr_mret = 32'h3020_0073;
  localparam logic [`XLEN-1:0] instr_wfi  = 32'h1050_0073;

  // ##############################
  // Records
  // ##############################

  typedef struct packed {
    logic valid;
    logic wren;
    logic rden1;
    logic rden2;
    logic fence;
    logic mret;
    logic wfi;
  } op_flags_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       instr;
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`REG_ADDR_W-1:0] raddr1;
    logic [`REG_ADDR_W-1:0] raddr2;
    unit_t                  unit;
    op_flags_t              op;
  } decoded_t;

  localparam decoded_t empty_decoded = '0; // A bubble. Nothing valid.

endpackage

// ==== design/issue_queue.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_queue import issue_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  issue_if.consumer pair_bus,
  input  logic      exec_stall,
  output decoded_t  issue0,
  output decoded_t  issue1,
  output logic      fetch_stall
);

  localparam int ptr_w = $clog2(`ISSUE_DEPTH);
  localparam int cnt_w = ptr_w + 1;
  localparam logic [cnt_w-1:0] half_depth = cnt_w'(`ISSUE_DEPTH / 2);

  decoded_t buffer      [`ISSUE_DEPTH];
  decoded_t buffer_next [`ISSUE_DEPTH];

  logic [ptr_w-1:0] wptr;
  logic [ptr_w-1:0] rptr;
  logic [cnt_w-1:0] count;

  logic [ptr_w-1:0] wptr_next;
  logic [ptr_w-1:0] rptr_head;   // Read pointer after a possible flush.
  logic [ptr_w-1:0] rptr_second;
  logic [ptr_w-1:0] rptr_next;
  logic [cnt_w-1:0] count_wr;    // Entries after this cycle's writes.
  logic [cnt_w-1:0] count_next;

  decoded_t   head0;
  decoded_t   head1;
  logic       serial;
  logic       unit_clash;
  logic       raw_hazard;
  logic [1:0] pass;

  // ##############################
  // Write side
  // ##############################

  always_comb begin
    buffer_next = buffer;
    wptr_next   = wptr;
    rptr_head   = rptr;
    count_wr    = count;
    if (pair_bus.flush) begin
      wptr_next = '0;
      rptr_head = '0;
      count_wr  = '0;
    end else if (!fetch_stall) begin
      if (pair_bus.pair0.op.valid) begin
        buffer_next[wptr_next] = pair_bus.pair0;
        wptr_next = wptr_next + 1'b1;
        count_wr  = count_wr + 1'b1;
      end
      if (pair_bus.pair1.op.valid) begin
        buffer_next[wptr_next] = pair_bus.pair1;
        wptr_next = wptr_next + 1'b1;
        count_wr  = count_wr + 1'b1;
      end
    end
  end

  // ##############################
  // Pairing and issue
  // ##############################

  // The incoming pair is visible here in the same cycle it is written.
  assign rptr_second = rptr_head + 1'b1;
  assign head0 = (count_wr > cnt_w'(0)) ? buffer_next[rptr_head] : empty_decoded;
  assign head1 = (count_wr > cnt_w'(1)) ? buffer_next[rptr_second] : empty_decoded;

  assign serial = head1.op.fence | head1.op.mret | head1.op.wfi;

  // The ALU is duplicated across both lanes, so only the other units conflict.
  assign unit_clash = (head0.unit == head1.unit) &&
                      (head0.unit != unit_alu) && (head0.unit != unit_none);

  always_comb begin
    raw_hazard = 1'b0;
    if (head0.op.wren) begin
      if (head1.op.rden1 && (head1.raddr1 == head0.waddr)) begin
        raw_hazard = 1'b1;
      end
      if (head1.op.rden2 && (head1.raddr2 == head0.waddr)) begin
        raw_hazard = 1'b1;
      end
    end
  end

  always_comb begin
    if (serial || unit_clash || raw_hazard) begin
      pass = 2'd1;
    end else begin
      pass = 2'd2;
    end
    if (exec_stall) begin
      pass = 2'd0;
    end
    if (count_wr < cnt_w'(pass)) begin
      pass = count_wr[1:0]; // Fewer than two entries held.
    end
  end

  assign count_next = count_wr - cnt_w'(pass);
  assign rptr_next  = rptr_head + ptr_w'(pass);

  assign issue0 = (pass > 2'd0) ? head0 : empty_decoded;
  assign issue1 = (pass > 2'd1) ? head1 : empty_decoded;

  // ##############################
  // State
  // ##############################

  always_ff @(posedge clock) begin
    buffer <= buffer_next;
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wptr        <= '0;
      rptr        <= '0;
      count       <= '0;
      fetch_stall <= 1'b0;
    end else begin
      wptr        <= wptr_next;
      rptr        <= rptr_next;
      count       <= count_next;
      fetch_stall <= (count_next > half_depth); // Leaves room for one held pair.
    end
  end

endmodule

// ==== design/issue_top.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_top import issue_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_valid0,
  input  logic             fetch_valid1,
  input  logic [`XLEN-1:0] fetch_pc0,
  input  logic [`XLEN-1:0] fetch_pc1,
  input  logic [`XLEN-1:0] fetch_instr0,
  input  logic [`XLEN-1:0] fetch_instr1,
  input  logic             clear,
  input  logic             exec_stall,
  output logic             fetch_stall,
  output logic             issue_valid0,
  output logic [`XLEN-1:0] issue_pc0,
  output logic [`XLEN-1:0] issue_instr0,
  output logic             issue_valid1,
  output logic [`XLEN-1:0] issue_pc1,
  output logic [`XLEN-1:0] issue_instr1
);

  issue_if pair_bus ();

  decoded_t issue0;
  decoded_t issue1;

  pair_decoder decoder0 (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid0 (fetch_valid0),
    .fetch_valid1 (fetch_valid1),
    .fetch_pc0    (fetch_pc0),
    .fetch_pc1    (fetch_pc1),
    .fetch_instr0 (fetch_instr0),
    .fetch_instr1 (fetch_instr1),
    .clear        (clear),
    .fetch_stall  (fetch_stall),
    .pair_bus     (pair_bus)
  );

  issue_queue queue0 (
    .clock       (clock),
    .reset       (reset),
    .pair_bus    (pair_bus),
    .exec_stall  (exec_stall),
    .issue0      (issue0),
    .issue1      (issue1),
    .fetch_stall (fetch_stall)
  );

  // Lane 0 always carries the older instruction.
  assign issue_valid0 = issue0.op.valid;
  assign issue_pc0    = issue0.pc;
  assign issue_instr0 = issue0.instr;
  assign issue_valid1 = issue1.op.valid;
  assign issue_pc1    = issue1.pc;
  assign issue_instr1 = issue1.instr;

endmodule

// ==== design/pair_decoder.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module pair_decoder import issue_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_valid0,
  input  logic             fetch_valid1,
  input  logic [`XLEN-1:0] fetch_pc0,
  input  logic [`XLEN-1:0] fetch_pc1,
  input  logic [`XLEN-1:0] fetch_instr0,
  input  logic [`XLEN-1:0] fetch_instr1,
  input  logic             clear,
  input  logic             fetch_stall,
  issue_if.producer        pair_bus
);

  // ##############################
  // Single word decode
  // ##############################

  function automatic decoded_t decode_word(
    input logic             valid,
    input logic [`XLEN-1:0] pc,
    input logic [`XLEN-1:0] word
  );
    decoded_t               rec;
    opcode_t                opcode;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rec    = empty_decoded;
    opcode = opcode_t'(word[6:0]);
    rd     = word[11:7];
    funct3 = word[14:12];
    funct7 = word[31:25];

    rec.pc     = pc;
    rec.instr  = word;
    rec.waddr  = rd;
    rec.raddr1 = word[19:15];
    rec.raddr2 = word[24:20];

    // Writes to x0 are dropped here so the queue never sees a false dependency.
    case (opcode)
      op_load: begin
        rec.unit     = unit_lsu;
        rec.op.rden1 = 1'b1;
        rec.op.wren  = (rd != '0);
      end
      op_store: begin
        rec.unit     = unit_lsu;
        rec.op.rden1 = 1'b1;
        rec.op.rden2 = 1'b1;
      end
      op_branch: begin
        rec.unit     = unit_bcu;
        rec.op.rden1 = 1'b1;
        rec.op.rden2 = 1'b1;
      end
      op_jal: begin
        rec.unit    = unit_bcu;
        rec.op.wren = (rd != '0);
      end
      op_jalr: begin
        rec.unit     = unit_bcu;
        rec.op.rden1 = 1'b1;
        rec.op.wren  = (rd != '0);
      end
      op_lui, op_auipc: begin
        rec.unit    = unit_alu;
        rec.op.wren = (rd != '0);
      end
      op_imm: begin
        rec.unit     = unit_alu;
        rec.op.rden1 = 1'b1;
        rec.op.wren  = (rd != '0);
      end
      op_reg: begin
        if (funct7 == 7'b0000001) begin
          rec.unit = funct3[2] ? unit_div : unit_mul; // M extension.
        end else begin
          rec.unit = unit_alu;
        end
        rec.op.rden1 = 1'b1;
        rec.op.rden2 = 1'b1;
        rec.op.wren  = (rd != '0);
      end
      op_fence: begin
        rec.op.fence = 1'b1;
      end
      op_system: begin
        if (word == instr_mret) begin
          rec.op.mret = 1'b1;
        end else if (word == instr_wfi) begin
          rec.op.wfi = 1'b1;
        end else begin
          rec.unit = unit_csr;
          // Register forms of csrrw/csrrs/csrrc read rs1.
          rec.op.rden1 = (funct3 != 3'b000) && !funct3[2];
          rec.op.wren  = (funct3 != 3'b000) && (rd != '0);
        end
      end
      default: begin
        rec.unit = unit_none; // Unknown opcodes still flow through in order.
      end
    endcase

    rec.op.valid = valid;
    return valid ? rec : empty_decoded;
  endfunction

  // ##############################
  // Pair register
  // ##############################

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      pair_bus.pair0 <= empty_decoded;
      pair_bus.pair1 <= empty_decoded;
      pair_bus.flush <= 1'b0;
    end else if (clear) begin
      pair_bus.pair0 <= empty_decoded; // The words offered with the clear are lost.
      pair_bus.pair1 <= empty_decoded;
      pair_bus.flush <= 1'b1;
    end else begin
      pair_bus.flush <= 1'b0;
      if (!fetch_stall) begin
        pair_bus.pair0 <= decode_word(fetch_valid0, fetch_pc0, fetch_instr0);
        pair_bus.pair1 <= decode_word(fetch_valid1, fetch_pc1, fetch_instr1);
      end
    end
  end

endmodule

// ==== src.f ====
+incdir+design
design/issue_pkg.sv
design/issue_if.sv
design/pair_decoder.sv
design/issue_queue.sv
design/issue_top.sv
testbench/issue_tb.sv

// ==== testbench/issue_tb.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_tb;

  localparam int max_cycles = 4000; // About twice the stimulus length.
  localparam int u_none = 0;
  localparam int u_alu  = 1;
  localparam int u_lsu  = 2;
  localparam int u_bcu  = 3;
  localparam int u_mul  = 4;
  localparam int u_div  = 5;
  localparam int u_csr  = 6;

  logic             clock;
  logic             reset;
  logic             fetch_valid0;
  logic             fetch_valid1;
  logic [`XLEN-1:0] fetch_pc0;
  logic [`XLEN-1:0] fetch_pc1;
  logic [`XLEN-1:0] fetch_instr0;
  logic [`XLEN-1:0] fetch_instr1;
  logic             clear;
  logic             exec_stall;
  logic             fetch_stall;
  logic             issue_valid0;
  logic [`XLEN-1:0] issue_pc0;
  logic [`XLEN-1:0] issue_instr0;
  logic             issue_valid1;
  logic [`XLEN-1:0] issue_pc1;
  logic [`XLEN-1:0] issue_instr1;

  logic [63:0] model[$]; // Taken words as {pc, instr} with the oldest first.
  int          pending;  // Words of the model still in the decoder register.
  logic        exp_fs;
  logic        flush_cycle;
  logic [31:0] next_pc;
  int          checks;
  int          errors;
  int          cycles;

  issue_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the stimulus did not finish.", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // ##############################
  // Instruction classes
  // ##############################

  function automatic int unit_of(input logic [31:0] w);
    case (w[6:0])
      7'h03, 7'h23: return u_lsu;
      7'h63, 7'h6f, 7'h67: return u_bcu;
      7'h37, 7'h17, 7'h13: return u_alu;
      7'h33: return (w[31:25] == 7'd1) ? (w[14] ? u_div : u_mul) : u_alu;
      7'h73: return (w == 32'h3020_0073 || w == 32'h1050_0073) ? u_none : u_csr;
      default: return u_none;
    endcase
  endfunction

  // Returns the destination register or zero when nothing is written.
  function automatic logic [4:0] dest_of(input logic [31:0] w);
    case (w[6:0])
      7'h03, 7'h6f, 7'h67, 7'h37, 7'h17, 7'h13, 7'h33: return w[11:7];
      7'h73: return (w[14:12] != 3'd0) ? w[11:7] : 5'd0;
      default: return 5'd0;
    endcase
  endfunction

  function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
    logic use1;
    logic use2;
    use1 = 1'b0;
    use2 = 1'b0;
    case (w[6:0])
      7'h03, 7'h67, 7'h13: use1 = 1'b1;
      7'h23, 7'h63, 7'h33: begin
        use1 = 1'b1;
        use2 = 1'b1;
      end
      7'h73: use1 = (w[14:12] >= 3'd1) && (w[14:12] <= 3'd3);
      default: use1 = 1'b0;
    endcase
    return (use1 && w[19:15] == r) || (use2 && w[24:20] == r);
  endfunction

  function automatic logic is_serial(input logic [31:0] w);
    return (w[6:0] == 7'h0f) || (w == 32'h3020_0073) || (w == 32'h1050_0073);
  endfunction

  function automatic logic can_pair(input logic [31:0] first, input logic [31:0] second);
    int         u;
    logic [4:0] rd;
    u  = unit_of(first);
    rd = dest_of(first);
    if (is_serial(second)) return 1'b0;
    if (u == unit_of(second) && u != u_none && u != u_alu) return 1'b0;
    if (rd != 5'd0 && reads_reg(second, rd)) return 1'b0;
    return 1'b1;
  endfunction

  // Small register numbers make hazards common.
  function automatic logic [31:0] random_word();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rd  = 5'($urandom_range(0, 3));
    rs1 = 5'($urandom_range(0, 3));
    rs2 = 5'($urandom_range(0, 3));
    case ($urandom_range(0, 13))
      0: return {12'h010, rs1, 3'b010, rd, 7'h03};
      1: return {7'h00, rs2, rs1, 3'b010, 5'h04, 7'h23};
      2: return {7'h00, rs2, rs1, 3'b000, 5'h08, 7'h63};
      3: return {20'h00100, rd, 7'h6f};
      4: return {12'h000, rs1, 3'b000, rd, 7'h67};
      5: return {20'h12345, rd, 7'h37};
      6: return {12'h001, rs1, 3'b000, rd, 7'h13};
      7: return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
      8: return {7'h01, rs2, rs1, 3'b000, rd, 7'h33};
      9: return {7'h01, rs2, rs1, 3'b100, rd, 7'h33};
      10: return {12'h300, rs1, 3'b001, rd, 7'h73};
      11: return 32'h0ff0_000f;
      12: return 32'h3020_0073;
      default: return 32'h1050_0073;
    endcase
  endfunction

  // ##############################
  // Checking
  // ##############################

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  // Runs just before the rising edge, then moves the model across that edge.
  task automatic compare_outputs();
    int          avail;
    int          exp_n;
    int          unwritten;
    logic        fs_next;
    logic [63:0] head;
    expect_equal("fetch_stall", 32'(fetch_stall), 32'(exp_fs));
    avail = flush_cycle ? 0 : model.size() - (exp_fs ? pending : 0);
    if (exec_stall || avail == 0) exp_n = 0;
    else if (avail == 1) exp_n = 1;
    else exp_n = can_pair(model[0][31:0], model[1][31:0]) ? 2 : 1;
    if (exec_stall) expect_true(!issue_valid0, "An instruction issued during exec_stall.");
    if (flush_cycle) expect_true(!issue_valid0, "An instruction issued right after a clear.");
    expect_true(issue_valid0 || !issue_valid1, "Slot 1 issued without slot 0.");
    expect_equal("issue_valid0", 32'(issue_valid0), 32'(exp_n > 0));
    expect_equal("issue_valid1", 32'(issue_valid1), 32'(exp_n > 1));
    if (issue_valid0 && issue_valid1) begin
      expect_true(can_pair(issue_instr0, issue_instr1), "An issued pair breaks a pairing rule.");
    end
    if (issue_valid0) begin
      expect_true(model.size() > 0, "Slot 0 issued with nothing outstanding.");
      if (model.size() > 0) begin
        head = model.pop_front();
        expect_equal("issue_pc0", issue_pc0, head[63:32]);
        expect_equal("issue_instr0", issue_instr0, head[31:0]);
      end
    end
    if (issue_valid1) begin
      expect_true(model.size() > 0, "Slot 1 issued with nothing outstanding.");
      if (model.size() > 0) begin
        head = model.pop_front();
        expect_equal("issue_pc1", issue_pc1, head[63:32]);
        expect_equal("issue_instr1", issue_instr1, head[31:0]);
      end
    end
    unwritten = exp_fs ? pending : 0; // A held pair is not in the queue yet.
    fs_next   = (model.size() - unwritten) > `ISSUE_DEPTH / 2;
    if (clear) begin
      model.delete();
      pending = 0;
    end else if (!exp_fs) begin
      pending = 0;
      if (fetch_valid0) begin
        model.push_back({fetch_pc0, fetch_instr0});
        pending++;
      end
      if (fetch_valid1) begin
        model.push_back({fetch_pc1, fetch_instr1});
        pending++;
      end
    end
    flush_cycle = clear;
    exp_fs      = fs_next;
  endtask

  // ##############################
  // Stimulus
  // ##############################

  task automatic drive_cycle(input logic v0, input logic v1, input logic [31:0] w0,
                             input logic [31:0] w1, input logic clr, input logic stall);
    @(negedge clock);
    fetch_valid0 = v0;
    fetch_valid1 = v1;
    fetch_instr0 = w0;
    fetch_instr1 = w1;
    fetch_pc0    = next_pc;
    fetch_pc1    = next_pc + 32'd4;
    next_pc      = next_pc + 32'd8;
    clear        = clr;
    exec_stall   = stall;
    #5;
    compare_outputs();
  endtask

  task automatic drain_model();
    while (model.size() > 0) begin
      drive_cycle(1'b0, 1'b0, 32'h13, 32'h13, 1'b0, 1'b0);
    end
  endtask

  task automatic pair_case(input logic [31:0] w0, input logic [31:0] w1);
    drain_model();
    drive_cycle(1'b1, 1'b1, w0, w1, 1'b0, 1'b0);
    drive_cycle(1'b0, 1'b0, 32'h13, 32'h13, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h1661_b11b));
    reset        = 1'b0;
    fetch_valid0 = 1'b0;
    fetch_valid1 = 1'b0;
    fetch_pc0    = '0;
    fetch_pc1    = '0;
    fetch_instr0 = '0;
    fetch_instr1 = '0;
    clear        = 1'b0;
    exec_stall   = 1'b0;
    pending      = 0;
    exp_fs       = 1'b0;
    flush_cycle  = 1'b0;
    next_pc      = 32'h0000_1000;
    checks       = 0;
    errors       = 0;
    cycles       = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    repeat (1100) begin
      drive_cycle(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), random_word(),
                  random_word(), 1'b0, ($urandom_range(0, 7) == 0));
    end
    drain_model();

    pair_case(32'h0020_82b3, 32'h0ff0_000f); // add then fence.
    pair_case(32'h0020_82b3, 32'h3020_0073);
    pair_case(32'h0020_82b3, 32'h1050_0073);
    pair_case(32'h0ff0_000f, 32'h0020_82b3); // A fence in slot 0 may pair.
    pair_case(32'h0001_2403, 32'h0031_2223); // Two LSU users.
    pair_case(32'h0220_84b3, 32'h0241_8533);
    pair_case(32'h0220_c5b3, 32'h0241_c633);
    pair_case(32'h0020_8463, 32'h0100_006f);
    pair_case(32'h3000_96f3, 32'h3400_2773);
    pair_case(32'h0020_82b3, 32'h0011_8393); // Two ALU users pair.
    pair_case(32'h0220_84b3, 32'h0220_c5b3);
    pair_case(32'h0020_82b3, 32'h0012_8333); // x5 read on rs1.
    pair_case(32'h0020_82b3, 32'h0050_8333); // x5 read on rs2.
    pair_case(32'h0000_0013, 32'h0000_00b3);
    pair_case(32'h0001_2403, 32'h0014_0333);
    pair_case(32'h0001_2403, 32'h0020_82b3);
    drain_model();

    // Long enough to push the queue into fetch stall.
    repeat (30) drive_cycle(1'b1, 1'b1, random_word(), random_word(), 1'b0, 1'b1);
    drain_model();

    repeat (500) begin
      drive_cycle(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), random_word(),
                  random_word(), ($urandom_range(0, 15) == 0), ($urandom_range(0, 5) == 0));
    end
    drain_model();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
